/* src/QuplsPkg.sv */
package QuplsPkg;

	// ==============================
	// Widths
	// ==============================

	// One instruction word of an instruction group
	localparam int InsWidth = 40;
	// A fully decoded immediate constant
	localparam int ImmWidth = 64;

	// Float precision field value that selects double precision
	localparam logic [1:0] FltPrecDouble = 2'd2;

	// ==============================
	// Opcodes
	// ==============================

	// Codes are fixed so that stimulus can build groups bit by bit
	typedef enum logic [6:0] {
		// Arithmetic with a signed immediate
		OP_ADDI   = 7'h04,
		OP_SUBFI  = 7'h05,
		OP_CMPI   = 7'h06,
		OP_MULI   = 7'h07,
		OP_DIVI   = 7'h08,
		OP_SLTI   = 7'h09,
		// Logical and unsigned arithmetic
		OP_ANDI   = 7'h0A,
		OP_ORI    = 7'h0B,
		OP_EORI   = 7'h0C,
		OP_MULUI  = 7'h0D,
		OP_DIVUI  = 7'h0E,
		OP_CSR    = 7'h0F,
		// Float operations, precision sits in bits 26:25
		OP_FLT2   = 7'h12,
		OP_FLT3   = 7'h13,
		// Flow control
		OP_JSR    = 7'h20,
		OP_RTD    = 7'h21,
		OP_Bcc    = 7'h28,
		OP_BccU   = 7'h29,
		OP_FBccH  = 7'h2A,
		OP_FBccS  = 7'h2B,
		OP_FBccD  = 7'h2C,
		OP_FBccQ  = 7'h2D,
		// Loads
		OP_LDB    = 7'h40,
		OP_LDBU   = 7'h41,
		OP_LDW    = 7'h42,
		OP_LDWU   = 7'h43,
		OP_LDT    = 7'h44,
		OP_LDTU   = 7'h45,
		OP_LDO    = 7'h46,
		OP_LDA    = 7'h4A,
		OP_CACHE  = 7'h4F,
		// Stores
		OP_STB    = 7'h50,
		OP_STW    = 7'h51,
		OP_STT    = 7'h52,
		OP_STO    = 7'h53,
		OP_FENCE  = 7'h5F,
		// Postfix words carrying 32 constant bits each
		OP_PFXA32 = 7'h70,
		OP_PFXB32 = 7'h74,
		OP_PFXC32 = 7'h78,
		// Vector qualifiers
		OP_VEC    = 7'h7C,
		OP_VECZ   = 7'h7D
	} opcode_e;

	// ==============================
	// Instruction word
	// ==============================

	// The same word is either a regular instruction or a postfix
	// carrying a constant, and the opcode sits at the bottom in both
	typedef union packed {
		struct packed {
			logic [InsWidth-8:0] payload;
			opcode_e opcode;
		} any;
		struct packed {
			logic [31:0] imm;
			logic reserved;
			opcode_e opcode;
		} pfx;
	} instruction_t;

endpackage

/* src/fpCvt32To64.sv */
`timescale 1ns/100ps

// Widens an IEEE single to an IEEE double. Every single value is exactly
// representable as a double, so no rounding is needed
module fpCvt32To64 (
	input  logic [31:0] single,
	output logic [63:0] double
);

	// Double bias 1023 less single bias 127
	localparam logic [10:0] BiasDelta = 11'd896;
	// Mantissa grows from 23 to 52 bits
	localparam int ManPad = 29;

	logic sign;
	logic [7:0] expSingle;
	logic [22:0] manSingle;
	logic [10:0] expDouble;

	// Split the single into its fields
	assign sign = single[31];
	assign expSingle = single[30:23];
	assign manSingle = single[22:0];

	// Normal exponent moved to the double bias
	assign expDouble = {3'b000, expSingle} + BiasDelta;

	always_comb begin
		if (expSingle == 8'h00) begin
			// Zero and denormals both come out as zero of the same sign
			double = {sign, 63'd0};
		end
		else if (expSingle == 8'hFF) begin
			// Infinity and NaN keep the mantissa so a NaN payload survives
			double = {sign, 11'h7FF, manSingle, {ManPad{1'b0}}};
		end
		else begin
			// Normal number, mantissa is left aligned and zero padded
			double = {sign, expDouble, manSingle, {ManPad{1'b0}}};
		end
	end

endmodule

/* src/QuplsImmBase.sv */
`timescale 1ns/100ps

// Decodes the immediate built into the primary instruction of a group
// and flags a double-precision float operation for the postfix scan
module QuplsImmBase import QuplsPkg::*; (
	input  instruction_t primary,
	output logic [ImmWidth-1:0] baseImmB,
	output logic [ImmWidth-1:0] baseImmC,
	output logic cvtDouble
);

	// Instruction bits rebuilt from the regular view so that the field
	// slices below use the instruction bit numbers directly
	logic [InsWidth-1:0] insBits;
	opcode_e opcode;

	assign opcode = primary.any.opcode;
	assign insBits = {primary.any.payload, primary.any.opcode};

	always_comb begin
		baseImmB = '0;
		baseImmC = '0;
		case (opcode)
			// Signed 21-bit immediate in the top of the word
			OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI,
			OP_RTD, OP_JSR,
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA,
			OP_CACHE,
			OP_STB, OP_STW, OP_STT, OP_STO:
				baseImmB = {{(ImmWidth-21){insBits[39]}}, insBits[39:19]};
			// Ones above the field leave the upper bits of the operand alone
			OP_ANDI:
				baseImmB = {{(ImmWidth-21){1'b1}}, insBits[39:19]};
			// Unsigned 13-bit immediate
			OP_ORI, OP_EORI, OP_MULUI, OP_DIVUI:
				baseImmB = {{(ImmWidth-13){1'b0}}, insBits[31:19]};
			// CSR number
			OP_CSR:
				baseImmB = {{(ImmWidth-11){1'b0}}, insBits[29:19]};
			// Fence mask
			OP_FENCE:
				baseImmB = {{(ImmWidth-16){1'b0}}, insBits[23:8]};
			// Branch displacement is split across two fields
			OP_Bcc, OP_BccU, OP_FBccH, OP_FBccS, OP_FBccD, OP_FBccQ:
				baseImmC = {{(ImmWidth-17){insBits[39]}}, insBits[39:25], insBits[12:11]};
			default: begin
				baseImmB = '0;
				baseImmC = '0;
			end
		endcase
	end

	// A postfix for a double float must be widened, not sign extended
	assign cvtDouble = (opcode == OP_FLT2 || opcode == OP_FLT3) &&
		insBits[26:25] == FltPrecDouble;

	// Only branches carry a C immediate and they never carry a B one, so
	// both are never live for the same primary word
	pBaseExclusive: assert property (@(primary)
		!((baseImmB != '0) && (baseImmC != '0)))
		else $error("Base B and C immediates both nonzero");

endmodule

/* src/QuplsPostfixScan.sv */
`timescale 1ns/100ps

// Scans the slots behind the primary instruction for postfix words.
// Postfixes must come in A, B, C order with at most two of each kind
module QuplsPostfixScan import QuplsPkg::*; #(
	parameter int NumSlots = 6
) (
	input  logic clk,
	input  instruction_t [NumSlots-1:0] group,
	input  logic cvtDouble,
	output logic [ImmWidth-1:0] pfxImmA,
	output logic [ImmWidth-1:0] pfxImmB,
	output logic [ImmWidth-1:0] pfxImmC,
	output logic havePfxA,
	output logic havePfxB,
	output logic havePfxC
);

	// ==============================
	// Slot scan
	// ==============================

	// Room for an index one past the last slot
	localparam int IdxWidth = $clog2(NumSlots) + 1;
	localparam int WordWidth = 32;
	localparam int PfxKinds = 3;
	// Postfix opcode expected in each scan stage
	localparam opcode_e PfxOp [PfxKinds] = '{OP_PFXA32, OP_PFXB32, OP_PFXC32};

	logic [IdxWidth-1:0] ndx;
	logic [IdxWidth-1:0] slotA;
	logic [PfxKinds-1:0] have;
	logic [PfxKinds-1:0] haveHigh;
	logic [WordWidth-1:0] lowWord [PfxKinds];
	logic [WordWidth-1:0] highWord [PfxKinds];
	logic [ImmWidth-1:0] cvtImm [PfxKinds];
	logic [ImmWidth-1:0] lowExt [PfxKinds];
	logic [ImmWidth-1:0] pfxImm [PfxKinds];

	// True when the slot exists and holds the given opcode
	function automatic logic slotIs(input instruction_t [NumSlots-1:0] grp,
		input logic [IdxWidth-1:0] idx, input opcode_e op);
		return (idx < NumSlots) && (grp[idx].any.opcode == op);
	endfunction

	always_comb begin
		ndx = 1;
		slotA = '0;
		have = '0;
		haveHigh = '0;
		for (int k = 0; k < PfxKinds; k++) begin
			lowWord[k] = '0;
			highWord[k] = '0;
		end
		// One vector qualifier may sit between the primary and its postfixes
		if (slotIs(group, ndx, OP_VEC) || slotIs(group, ndx, OP_VECZ))
			ndx = ndx + 1'b1;
		for (int k = 0; k < PfxKinds; k++) begin
			if (slotIs(group, ndx, PfxOp[k])) begin
				if (k == 0)
					slotA = ndx;
				have[k] = 1'b1;
				lowWord[k] = group[ndx].pfx.imm;
				ndx = ndx + 1'b1;
				// A second postfix of the same kind supplies the upper half
				if (slotIs(group, ndx, PfxOp[k])) begin
					haveHigh[k] = 1'b1;
					highWord[k] = group[ndx].pfx.imm;
					ndx = ndx + 1'b1;
				end
			end
		end
	end

	// ==============================
	// Value build
	// ==============================

	for (genvar k = 0; k < PfxKinds; k++) begin : gPfx
		fpCvt32To64 i_fpCvt32To64 (
			.single(lowWord[k]),
			.double(cvtImm[k])
		);

		// Low word is either a float widened to double or a signed integer
		assign lowExt[k] = cvtDouble ? cvtImm[k] :
			{{(ImmWidth-WordWidth){lowWord[k][WordWidth-1]}}, lowWord[k]};
		assign pfxImm[k] = haveHigh[k] ? {highWord[k], lowExt[k][WordWidth-1:0]} : lowExt[k];
	end

	assign pfxImmA = pfxImm[0];
	assign pfxImmB = pfxImm[1];
	assign pfxImmC = pfxImm[2];
	assign havePfxA = have[0];
	assign havePfxB = have[1];
	assign havePfxC = have[2];

	// An A postfix can only come from a real slot behind the primary
	pSlotARange: assert property (@(posedge clk)
		havePfxA |-> (slotA >= 1 && slotA < NumSlots))
		else $error("Postfix A slot index out of range");

endmodule

/* src/QuplsImmMerge.sv */
`timescale 1ns/100ps

// Chooses postfix constants over built-in immediates and registers the
// result together with a one-cycle valid pulse
module QuplsImmMerge import QuplsPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic insValid,
	input  logic [ImmWidth-1:0] baseImmB,
	input  logic [ImmWidth-1:0] baseImmC,
	input  logic [ImmWidth-1:0] pfxImmA,
	input  logic [ImmWidth-1:0] pfxImmB,
	input  logic [ImmWidth-1:0] pfxImmC,
	input  logic havePfxA,
	input  logic havePfxB,
	input  logic havePfxC,
	output logic [ImmWidth-1:0] imma,
	output logic [ImmWidth-1:0] immb,
	output logic [ImmWidth-1:0] immc,
	output logic immValid
);

	// ==============================
	// Output registers
	// ==============================

	always_ff @(posedge clk) begin
		if (reset) begin
			imma <= '0;
			immb <= '0;
			immc <= '0;
			immValid <= 1'b0;
		end
		else begin
			immValid <= insValid;
			// Outputs only move on a strobe and hold their value otherwise
			if (insValid) begin
				// The primary word never carries an A immediate of its own
				imma <= havePfxA ? pfxImmA : '0;
				immb <= havePfxB ? pfxImmB : baseImmB;
				immc <= havePfxC ? pfxImmC : baseImmC;
			end
		end
	end

	// Two valid cycles in a row need two strobes in a row before them
	pValidPerStrobe: assert property (@(posedge clk) disable iff (reset)
		(immValid && $past(immValid)) |-> ($past(insValid) && $past(insValid, 2)))
		else $error("immValid held high without a matching strobe");

endmodule

/* src/QuplsDecodeImm.sv */
`timescale 1ns/100ps

// Immediate decode for one instruction group. Base decode and postfix
// scan run side by side and the merge stage registers the result
module QuplsDecodeImm import QuplsPkg::*; #(
	parameter int NumSlots = 6
) (
	input  logic clk,
	input  logic reset,
	input  logic insValid,
	input  instruction_t [NumSlots-1:0] ins,
	output logic [ImmWidth-1:0] imma,
	output logic [ImmWidth-1:0] immb,
	output logic [ImmWidth-1:0] immc,
	output logic immValid
);

	logic [ImmWidth-1:0] baseImmB;
	logic [ImmWidth-1:0] baseImmC;
	logic cvtDouble;
	logic [ImmWidth-1:0] pfxImmA;
	logic [ImmWidth-1:0] pfxImmB;
	logic [ImmWidth-1:0] pfxImmC;
	logic havePfxA;
	logic havePfxB;
	logic havePfxC;

	// Slot 0 is the primary instruction
	QuplsImmBase i_QuplsImmBase (
		.primary(ins[0]),
		.baseImmB(baseImmB),
		.baseImmC(baseImmC),
		.cvtDouble(cvtDouble)
	);

	// Scan sees the whole group and starts behind the primary
	QuplsPostfixScan #(
		.NumSlots(NumSlots)
	) i_QuplsPostfixScan (
		.clk(clk),
		.group(ins),
		.cvtDouble(cvtDouble),
		.pfxImmA(pfxImmA),
		.pfxImmB(pfxImmB),
		.pfxImmC(pfxImmC),
		.havePfxA(havePfxA),
		.havePfxB(havePfxB),
		.havePfxC(havePfxC)
	);

	QuplsImmMerge i_QuplsImmMerge (
		.clk(clk),
		.reset(reset),
		.insValid(insValid),
		.baseImmB(baseImmB),
		.baseImmC(baseImmC),
		.pfxImmA(pfxImmA),
		.pfxImmB(pfxImmB),
		.pfxImmC(pfxImmC),
		.havePfxA(havePfxA),
		.havePfxB(havePfxB),
		.havePfxC(havePfxC),
		.imma(imma),
		.immb(immb),
		.immc(immc),
		.immValid(immValid)
	);

endmodule

/* testbench/tbQuplsDecodeImm.sv */
`timescale 1ns/100ps

// Directed testbench for the immediate decoder of one instruction group
module tbQuplsDecodeImm import QuplsPkg::*; ();

	// ==============================
	// Run constants
	// ==============================

	localparam int NumSlots = 6;
	localparam int ResetCycles = 16;
	localparam logic [31:0] Seed = 32'he5c0;
	localparam int BaseTries = 4;
	localparam int NumBaseOps = 37;
	localparam int SingleTries = 3;
	localparam int PairTries = 3;
	localparam int NumPatterns = 7;
	localparam int NumFloatVals = 10;
	localparam int BurstLen = 8;
	localparam int IdleCycles = 5;
	localparam int PulseWait = 4;
	// A strobe, its edge and the sampling half cycle after it
	localparam int CyclesPerGroup = 3;
	localparam int NumGroups = NumBaseOps * BaseTries + 6 * SingleTries +
		NumPatterns * PairTries + NumFloatVals * 3 + 1;
	localparam int TestCycles = 2 * ResetCycles + NumGroups * CyclesPerGroup +
		BurstLen + IdleCycles + 4;
	localparam int CycleLimit = 2 * TestCycles;

	// Singles chosen to hit every branch of the widening rule
	localparam logic [31:0] FloatVals [NumFloatVals] = '{
		32'h3F800000, 32'hC0490FDB, 32'h00800000, 32'h00000000, 32'h80000000,
		32'h00000001, 32'h807FFFFF, 32'h7F800000, 32'hFF800000, 32'h7FC00001
	};

	logic clk;
	logic reset;
	logic insValid;
	instruction_t [NumSlots-1:0] ins;
	logic [ImmWidth-1:0] imma;
	logic [ImmWidth-1:0] immb;
	logic [ImmWidth-1:0] immc;
	logic immValid;

	int cycleCount;
	int errorCount;
	int checkCount;
	int testCount;
	int testErrorBase;
	int testCheckBase;

	QuplsDecodeImm #(
		.NumSlots(NumSlots)
	) i_QuplsDecodeImm (
		.clk(clk),
		.reset(reset),
		.insValid(insValid),
		.ins(ins),
		.imma(imma),
		.immb(immb),
		.immc(immc),
		.immValid(immValid)
	);

	always #2 clk = ~clk;

	// Watchdog on the total run length
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ==============================
	// Reference model
	// ==============================

	// Copies the fill bit into every position above the field
	function automatic logic [ImmWidth-1:0] extendField(input logic [ImmWidth-1:0] field,
		input int width, input logic fill);
		logic [ImmWidth-1:0] result;
		result = field;
		for (int b = width; b < ImmWidth; b++)
			result[b] = fill;
		return result;
	endfunction

	// Single to double, with denormals flushed and specials kept
	function automatic logic [ImmWidth-1:0] floatRule(input logic [31:0] s);
		logic [10:0] e;
		if (s[30:23] == 8'd0)
			return {s[31], 63'd0};
		if (s[30:23] == 8'hFF)
			e = 11'h7FF;
		else
			e = 11'(s[30:23]) - 11'd127 + 11'd1023;
		return {s[31], e, s[22:0], 29'd0};
	endfunction

	function automatic logic [InsWidth-1:0] wordAt(input instruction_t [NumSlots-1:0] grp,
		input int idx);
		return grp[idx];
	endfunction

	// Opcode of a slot, or an unused code past the end of the group
	function automatic logic [6:0] opcodeAt(input instruction_t [NumSlots-1:0] grp,
		input int idx);
		logic [InsWidth-1:0] w;
		if (idx >= NumSlots)
			return 7'h00;
		w = grp[idx];
		return w[6:0];
	endfunction

	// Built-in immediate of the primary word by opcode class
	task automatic baseRule(input logic [InsWidth-1:0] w, output logic [ImmWidth-1:0] eb,
		output logic [ImmWidth-1:0] ec);
		opcode_e op;
		op = opcode_e'(w[6:0]);
		eb = '0;
		ec = '0;
		if (op inside {OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI, OP_RTD, OP_JSR,
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_CACHE,
			OP_STB, OP_STW, OP_STT, OP_STO})
			eb = extendField(w[39:19], 21, w[39]);
		else if (op == OP_ANDI)
			eb = extendField(w[39:19], 21, 1'b1);
		else if (op inside {OP_ORI, OP_EORI, OP_MULUI, OP_DIVUI})
			eb = w[31:19];
		else if (op == OP_CSR)
			eb = w[29:19];
		else if (op == OP_FENCE)
			eb = w[23:8];
		else if (op inside {OP_Bcc, OP_BccU, OP_FBccH, OP_FBccS, OP_FBccD, OP_FBccQ})
			ec = extendField({w[39:25], w[12:11]}, 17, w[39]);
	endtask

	// Expected immediates of a whole group, postfixes taken in A, B, C order
	task automatic computeExpected(input instruction_t [NumSlots-1:0] grp,
		output logic [ImmWidth-1:0] ea, output logic [ImmWidth-1:0] eb,
		output logic [ImmWidth-1:0] ec);
		logic [InsWidth-1:0] w;
		logic [ImmWidth-1:0] val [3];
		logic found [3];
		logic dbl;
		opcode_e kinds [3];
		int slot;
		w = grp[0];
		kinds = '{OP_PFXA32, OP_PFXB32, OP_PFXC32};
		baseRule(w, eb, ec);
		dbl = (w[6:0] == OP_FLT2 || w[6:0] == OP_FLT3) && w[26:25] == FltPrecDouble;
		slot = 1;
		if (opcodeAt(grp, slot) inside {OP_VEC, OP_VECZ})
			slot++;
		for (int k = 0; k < 3; k++) begin
			found[k] = 1'b0;
			val[k] = '0;
			if (opcodeAt(grp, slot) == kinds[k]) begin
				found[k] = 1'b1;
				w = wordAt(grp, slot);
				val[k] = dbl ? floatRule(w[39:8]) : extendField(w[39:8], 32, w[39]);
				slot++;
				// The second word of a kind overwrites the upper half only
				if (opcodeAt(grp, slot) == kinds[k]) begin
					w = wordAt(grp, slot);
					val[k][63:32] = w[39:8];
					slot++;
				end
			end
		end
		ea = found[0] ? val[0] : '0;
		if (found[1])
			eb = val[1];
		if (found[2])
			ec = val[2];
	endtask

	// ==============================
	// Stimulus and checking
	// ==============================

	function automatic logic [InsWidth-1:0] randWord(input opcode_e op);
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return {r[InsWidth-1:7], op};
	endfunction

	function automatic logic [InsWidth-1:0] pfxWord(input opcode_e op, input logic [31:0] value);
		logic [InsWidth-1:0] w;
		w = randWord(op);
		w[39:8] = value;
		return w;
	endfunction

	// Slots past the given sequence get a plain arithmetic instruction
	task automatic buildGroup(input logic [InsWidth-1:0] primary, input opcode_e seq[$],
		output instruction_t [NumSlots-1:0] grp);
		grp[0] = primary;
		for (int s = 1; s < NumSlots; s++) begin
			if (s - 1 < seq.size())
				grp[s] = randWord(seq[s - 1]);
			else
				grp[s] = randWord(OP_ADDI);
		end
	endtask

	task automatic randomGroup(output instruction_t [NumSlots-1:0] grp);
		opcode_e primPool [5];
		opcode_e slotPool [5];
		primPool = '{OP_ADDI, OP_ANDI, OP_Bcc, OP_FLT2, OP_CSR};
		slotPool = '{OP_PFXA32, OP_PFXB32, OP_PFXC32, OP_VEC, OP_ADDI};
		grp[0] = randWord(primPool[$urandom() % 5]);
		for (int s = 1; s < NumSlots; s++)
			grp[s] = randWord(slotPool[$urandom() % 5]);
	endtask

	task automatic checkValue(input string what, input logic [ImmWidth-1:0] got,
		input logic [ImmWidth-1:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkOutputs(input instruction_t [NumSlots-1:0] grp, input string label);
		logic [ImmWidth-1:0] ea;
		logic [ImmWidth-1:0] eb;
		logic [ImmWidth-1:0] ec;
		computeExpected(grp, ea, eb, ec);
		checkValue($sformatf("%s imma", label), imma, ea);
		checkValue($sformatf("%s immb", label), immb, eb);
		checkValue($sformatf("%s immc", label), immc, ec);
	endtask

	// One strobe, then wait at falling edges for the valid pulse
	task automatic applyGroup(input instruction_t [NumSlots-1:0] grp);
		int waitCycles;
		@(posedge clk);
		ins <= grp;
		insValid <= 1'b1;
		@(posedge clk);
		insValid <= 1'b0;
		waitCycles = 0;
		@(negedge clk);
		while (!immValid && waitCycles < PulseWait) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!immValid) begin
			errorCount++;
			$display("No immValid pulse within %0d cycles of a strobe", PulseWait);
		end
	endtask

	task automatic runGroup(input instruction_t [NumSlots-1:0] grp, input string label);
		applyGroup(grp);
		checkOutputs(grp, label);
	endtask

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		insValid <= 1'b0;
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic beginTest();
		testErrorBase = errorCount;
		testCheckBase = checkCount;
	endtask

	task automatic endTest(input string name);
		int errs;
		errs = errorCount - testErrorBase;
		testCount++;
		$display("test %-18s %-6s checks %0d errors %0d", name, errs == 0 ? "ok" : "failed",
			checkCount - testCheckBase, errs);
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic testBaseImm();
		opcode_e ops[$];
		opcode_e noSeq[$];
		instruction_t [NumSlots-1:0] grp;
		logic [InsWidth-1:0] w;
		beginTest();
		// The last entry is an unused code that must decode to zeros
		ops = '{OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_SLTI, OP_ANDI, OP_ORI,
			OP_EORI, OP_MULUI, OP_DIVUI, OP_CSR, OP_RTD, OP_JSR, OP_LDB, OP_LDBU, OP_LDW,
			OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA, OP_CACHE, OP_STB, OP_STW, OP_STT,
			OP_STO, OP_FENCE, OP_Bcc, OP_BccU, OP_FBccH, OP_FBccS, OP_FBccD, OP_FBccQ,
			OP_FLT2, OP_FLT3, opcode_e'(7'h7F)};
		foreach (ops[i]) begin
			for (int t = 0; t < BaseTries; t++) begin
				w = randWord(ops[i]);
				// Alternate the top bit so both extension cases come up
				w[39] = t[0];
				buildGroup(w, noSeq, grp);
				runGroup(grp, $sformatf("opcode %h", ops[i]));
			end
		end
		endTest("base immediates");
	endtask

	task automatic testSinglePfx();
		opcode_e kinds [3];
		opcode_e prims [2];
		opcode_e seq[$];
		instruction_t [NumSlots-1:0] grp;
		logic [InsWidth-1:0] w;
		beginTest();
		kinds = '{OP_PFXA32, OP_PFXB32, OP_PFXC32};
		prims = '{OP_ADDI, OP_Bcc};
		for (int k = 0; k < 3; k++) begin
			for (int p = 0; p < 2; p++) begin
				for (int t = 0; t < SingleTries; t++) begin
					seq = '{kinds[k]};
					buildGroup(randWord(prims[p]), seq, grp);
					w = grp[1];
					w[39] = t[0];
					grp[1] = w;
					runGroup(grp, $sformatf("single kind %0d", k));
				end
			end
		end
		endTest("single postfix");
	endtask

	task automatic runPattern(input string name, input opcode_e seq[$]);
		opcode_e prims [3];
		instruction_t [NumSlots-1:0] grp;
		prims = '{OP_ADDI, OP_Bcc, OP_LDO};
		for (int t = 0; t < PairTries; t++) begin
			buildGroup(randWord(prims[$urandom() % 3]), seq, grp);
			runGroup(grp, name);
		end
	endtask

	task automatic testPfxPairs();
		opcode_e seq[$];
		beginTest();
		seq = '{OP_PFXA32, OP_PFXA32};
		runPattern("A pair", seq);
		seq = '{OP_VEC, OP_PFXB32, OP_PFXB32};
		runPattern("VEC B pair", seq);
		seq = '{OP_VECZ, OP_PFXC32, OP_PFXC32};
		runPattern("VECZ C pair", seq);
		seq = '{OP_PFXA32, OP_PFXA32, OP_PFXB32, OP_PFXB32, OP_PFXC32};
		runPattern("A B C", seq);
		seq = '{OP_VEC, OP_PFXA32, OP_PFXA32, OP_PFXC32, OP_PFXC32};
		runPattern("VEC A C", seq);
		// A behind B is out of order, so the model leaves imma at zero
		seq = '{OP_PFXB32, OP_PFXA32};
		runPattern("B then A", seq);
		seq = '{OP_VEC, OP_PFXC32, OP_PFXA32};
		runPattern("C then A", seq);
		endTest("postfix pairs");
	endtask

	task automatic testFloatCvt();
		opcode_e seq[$];
		instruction_t [NumSlots-1:0] grp;
		logic [InsWidth-1:0] w;
		beginTest();
		// Fixed anchor so the model itself is pinned to a known double
		w = randWord(OP_FLT2);
		w[26:25] = FltPrecDouble;
		seq = '{OP_PFXA32};
		buildGroup(w, seq, grp);
		grp[1] = pfxWord(OP_PFXA32, 32'h3F800000);
		applyGroup(grp);
		checkValue("1.0 widened", imma, 64'h3FF0000000000000);
		for (int v = 0; v < NumFloatVals; v++) begin
			w = randWord(OP_FLT2);
			w[26:25] = FltPrecDouble;
			seq = '{OP_PFXA32};
			buildGroup(w, seq, grp);
			grp[1] = pfxWord(OP_PFXA32, FloatVals[v]);
			runGroup(grp, $sformatf("FLT2 double %h", FloatVals[v]));
			// A second C word replaces the upper half of the widened value
			w = randWord(OP_FLT3);
			w[26:25] = FltPrecDouble;
			seq = '{OP_PFXC32, OP_PFXC32};
			buildGroup(w, seq, grp);
			grp[1] = pfxWord(OP_PFXC32, FloatVals[v]);
			runGroup(grp, $sformatf("FLT3 double %h", FloatVals[v]));
			w = randWord(OP_FLT2);
			w[26:25] = v[0] ? 2'd3 : 2'd1;
			seq = '{OP_PFXB32};
			buildGroup(w, seq, grp);
			grp[1] = pfxWord(OP_PFXB32, FloatVals[v]);
			runGroup(grp, $sformatf("FLT2 other %h", FloatVals[v]));
		end
		endTest("float conversion");
	endtask

	task automatic testTiming();
		instruction_t [NumSlots-1:0] burst [BurstLen];
		beginTest();
		applyReset();
		@(negedge clk);
		checkValue("immValid after reset", immValid, '0);
		checkValue("imma after reset", imma, '0);
		checkValue("immb after reset", immb, '0);
		checkValue("immc after reset", immc, '0);
		for (int i = 0; i < BurstLen; i++)
			randomGroup(burst[i]);
		// Each falling edge shows the result of the strobe one cycle earlier
		for (int i = 0; i < BurstLen; i++) begin
			@(posedge clk);
			ins <= burst[i];
			insValid <= 1'b1;
			@(negedge clk);
			checkValue($sformatf("immValid in burst %0d", i), immValid, (i > 0) ? 1 : 0);
			if (i > 0)
				checkOutputs(burst[i - 1], $sformatf("burst %0d", i - 1));
		end
		@(posedge clk);
		insValid <= 1'b0;
		@(negedge clk);
		checkValue("immValid for last burst", immValid, 1);
		checkOutputs(burst[BurstLen - 1], "last burst");
		// No strobe, so no pulse and the outputs stay put
		for (int i = 0; i < IdleCycles; i++) begin
			@(negedge clk);
			checkValue($sformatf("immValid idle %0d", i), immValid, '0);
			checkOutputs(burst[BurstLen - 1], $sformatf("idle %0d", i));
		end
		endTest("timing and reset");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		insValid = 1'b0;
		ins = '0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		void'($urandom(Seed));
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkValue("immValid out of reset", immValid, '0);
		testBaseImm();
		testSinglePfx();
		testPfxPairs();
		testFloatCvt();
		testTiming();
		$display("Totals: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* vlog.f */
src/QuplsPkg.sv
src/fpCvt32To64.sv
src/QuplsImmBase.sv
src/QuplsPostfixScan.sv
src/QuplsImmMerge.sv
src/QuplsDecodeImm.sv
testbench/tbQuplsDecodeImm.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tbQuplsDecodeImm
FILELIST = vlog.f
BUILD_DIR = obj_dir
PASS_MSG = Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
